// ==== Bender.yml ====
package:
  name: fp_core

sources:
  - include_dirs:
      - design
    files:
      - design/fp_types_pkg.sv
      - design/mop_pkg.sv
      - design/mop_if.sv
      - design/mop_sequencer.sv
      - design/operand_ram.sv
      - design/fp_preadder.sv
      - design/fp_mod_mul.sv
      - design/fp_core.sv
  - target: simulation
    include_dirs:
      - design
      - sim
    files:
      - sim/fp_core_tb.sv

// ==== design/fp_consts.svh ====
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// Prime field
`define FP_W     16
`define FP_P     65521
// 2**16 reduced modulo FP_P
`define FP_FOLD  15

// Operand memories
`define RF_AW    4
`define RF_DEPTH 16

// Program select
`define FUNC_W   2

// Stage latencies in cycles
`define LAT_READ 1
`define LAT_PRE  1
`define LAT_MUL  3
`define LAT_POST 1
`define LAT_WB   7

`endif

// ==== design/fp_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fp_consts.svh"

module fp_core
    import fp_types_pkg::*;
    import mop_pkg::*;
(
    input  wire         clk,
    input  wire         rstn,
    input  wire         run,
    input  wire func_t  n_func,
    input  wire         ext_wr_en,
    input  wire raddr_t ext_wr_addr,
    input  wire fe_t    ext_wr_data,
    input  wire raddr_t ext_rd_addr,
    output logic        busy,
    output logic        endflag,
    output fe_t         ext_rd_data
);

    localparam fe_t p_mod = fe_t'(`FP_P);

    mop_t                   mop_now;
    // Entry k holds the micro-op issued k cycles ago
    mop_t [`LAT_WB-1:1]     mop_dly;
    mop_t                   ctrl_pre;
    mop_t                   ctrl_post;
    mop_t                   ctrl_wb;
    fe_t                    rdata0, rdata1;
    fe_t                    pre_x, pre_y;
    fe_t                    mul_z;
    fe_t                    post_q;
    logic                   ram_we;
    raddr_t                 ram_waddr;
    fe_t                    ram_wdata;
    raddr_t                 ram1_raddr;

    mop_if mop_bus ();

    mop_sequencer u_seq (.clk, .rstn, .run, .n_func, .busy, .endflag, .mop_o(mop_bus));

    assign mop_now = mop_bus.mop;

    ////////////////////
    // Micro-op delay line
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mop_dly <= {(`LAT_WB-1){mop_nop}};
        end else begin
            mop_dly <= {mop_dly[`LAT_WB-2:1], mop_now};
        end
    end

    assign ctrl_pre  = mop_dly[`LAT_READ];
    assign ctrl_post = mop_dly[`LAT_READ + `LAT_PRE + `LAT_MUL];
    assign ctrl_wb   = mop_dly[`LAT_WB - `LAT_POST];

    // Host owns the write port and copy 1 reads while idle
    assign ram_we     = busy ? ctrl_wb.we  : ext_wr_en;
    assign ram_waddr  = busy ? ctrl_wb.dst : ext_wr_addr;
    assign ram_wdata  = busy ? post_q      : ext_wr_data;
    assign ram1_raddr = busy ? mop_now.src1 : ext_rd_addr;

    operand_ram u_ram0 (
        .clk, .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(mop_now.src0), .rdata(rdata0)
    );

    operand_ram u_ram1 (
        .clk, .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
        .raddr(ram1_raddr), .rdata(rdata1)
    );

    assign ext_rd_data = rdata1;

    fp_preadder u_pre (.clk, .rstn, .op(ctrl_pre.op), .a(rdata0), .b(rdata1), .x(pre_x), .y(pre_y));

    fp_mod_mul u_mul (.clk, .rstn, .x(pre_x), .y(pre_y), .z(mul_z));

    // Post-stage negation, zero stays zero
    always_ff @(posedge clk) begin
        post_q <= (ctrl_post.neg && mul_z != '0) ? fe_t'(p_mod - mul_z) : mul_z;
    end

endmodule

`default_nettype wire

// ==== design/fp_mod_mul.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fp_consts.svh"

module fp_mod_mul
    import fp_types_pkg::*;
(
    input  wire      clk,
    input  wire      rstn,
    input  wire fe_t x,
    input  wire fe_t y,
    output fe_t      z
);

    localparam fe_t        p_mod = fe_t'(`FP_P);
    localparam logic [3:0] fold  = 4'(`FP_FOLD);

    logic [2*`FP_W-1:0] prod_q;
    // High half times 15 plus low half stays below 2**20
    logic [`FP_W+3:0]   fold1_q;
    logic [`FP_W:0]     fold2;

    // Second fold is below twice the prime
    always_comb begin
        fold2 = {1'b0, fold1_q[`FP_W-1:0]} + fold1_q[`FP_W+3:`FP_W] * fold;
    end

    ////////////////////
    // Pipeline
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prod_q  <= '0;
            fold1_q <= '0;
            z       <= '0;
        end else begin
            prod_q  <= x * y;
            fold1_q <= prod_q[2*`FP_W-1:`FP_W] * fold + prod_q[`FP_W-1:0];
            if (fold2 >= {1'b0, p_mod}) begin
                z <= fe_t'(fold2 - {1'b0, p_mod});
            end else begin
                z <= fold2[`FP_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fp_preadder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fp_consts.svh"

module fp_preadder
    import fp_types_pkg::*;
    import mop_pkg::*;
(
    input  wire          clk,
    input  wire          rstn,
    input  wire mop_op_t op,
    input  wire fe_t     a,
    input  wire fe_t     b,
    output fe_t          x,
    output fe_t          y
);

    localparam fe_t p_mod = fe_t'(`FP_P);
    localparam fe_t one   = fe_t'(1);

    logic [`FP_W:0] sum;
    fe_t            mod_add;
    fe_t            mod_sub;

    // One correction by the prime is enough for reduced inputs
    always_comb begin
        sum     = {1'b0, a} + {1'b0, b};
        mod_add = (sum >= {1'b0, p_mod}) ? fe_t'(sum - {1'b0, p_mod}) : sum[`FP_W-1:0];
        mod_sub = (a < b) ? fe_t'(a - b + p_mod) : fe_t'(a - b);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            x <= '0;
            y <= '0;
        end else begin
            case (op)
                op_add:  begin x <= mod_add; y <= one;     end
                op_sub:  begin x <= mod_sub; y <= one;     end
                op_sqd:  begin x <= mod_add; y <= mod_sub; end
                default: begin x <= a;       y <= b;       end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/fp_types_pkg.sv ====
`default_nettype none

`include "fp_consts.svh"

package fp_types_pkg;

    // Field element, always below the prime
    typedef logic [`FP_W-1:0] fe_t;

    // Operand memory address
    typedef logic [`RF_AW-1:0] raddr_t;

    // Built-in program number
    typedef logic [`FUNC_W-1:0] func_t;

endpackage

`default_nettype wire

// ==== design/mop_if.sv ====
`timescale 1ns/1ns
`default_nettype none

////////////////////
// Micro-op issue bus
////////////////////

interface mop_if
    import mop_pkg::*;
();

    // Micro-op of the current cycle, nop when idle
    mop_t mop;

    // Sequencer side
    modport seq (
        output mop
    );

    // Datapath side
    modport dp (
        input mop
    );

endinterface

`default_nettype wire

// ==== design/mop_pkg.sv ====
`default_nettype none

package mop_pkg;
    import fp_types_pkg::*;

    // Opcodes, all arithmetic modulo the prime
    typedef enum logic [2:0] {
        op_nop = 3'd0,
        op_mul = 3'd1,
        op_add = 3'd2,
        op_sub = 3'd3,
        op_sqd = 3'd4
    } mop_op_t;

    // One micro-op as issued by the sequencer
    typedef struct packed {
        mop_op_t op;
        raddr_t  src0;
        raddr_t  src1;
        raddr_t  dst;
        logic    we;
        logic    neg;
    } mop_t;

    // Bubble, never writes back
    localparam mop_t mop_nop = '{
        op:   op_nop,
        src0: '0,
        src1: '0,
        dst:  '0,
        we:   1'b0,
        neg:  1'b0
    };

endpackage

`default_nettype wire

// ==== design/mop_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fp_consts.svh"

module mop_sequencer
    import fp_types_pkg::*;
    import mop_pkg::*;
(
    input  wire        clk,
    input  wire        rstn,
    input  wire        run,
    input  wire func_t n_func,
    output logic       busy,
    output logic       endflag,
    mop_if.seq         mop_o
);

    typedef logic [3:0] step_t;
    typedef enum logic [1:0] {st_idle, st_issue, st_drain} seq_state_t;

    localparam int drain_w = $clog2(`LAT_WB);

    seq_state_t         state;
    func_t              prog;
    step_t              pc;
    logic [drain_w-1:0] drain_cnt;

    function automatic mop_t uop(mop_op_t op, raddr_t s0, raddr_t s1, raddr_t d, logic neg);
        mop_t m;
        m.op   = op;
        m.src0 = s0;
        m.src1 = s1;
        m.dst  = d;
        m.we   = 1'b1;
        m.neg  = neg;
        return m;
    endfunction

    ////////////////////
    // Program ROM
    ////////////////////

    // Steps not listed are nops that space dependent ops
    function automatic mop_t rom_word(func_t p, step_t s);
        mop_t m;
        m = mop_nop;
        case (p)
            2'd0: if (s == 4'd0) m = uop(op_mul, 4'd0, 4'd1, 4'd2, 1'b0);
            2'd1: begin
                if (s == 4'd0)      m = uop(op_add, 4'd0, 4'd1, 4'd2, 1'b0);
                else if (s == 4'd1) m = uop(op_sub, 4'd0, 4'd1, 4'd3, 1'b0);
                else if (s == 4'd9) m = uop(op_mul, 4'd2, 4'd3, 4'd4, 1'b0);
            end
            2'd2: begin
                if (s == 4'd0)      m = uop(op_mul, 4'd0, 4'd0, 4'd1, 1'b0);
                else if (s == 4'd7) m = uop(op_mul, 4'd1, 4'd1, 4'd1, 1'b0);
            end
            default: begin
                if (s == 4'd0)      m = uop(op_mul, 4'd0, 4'd1, 4'd5, 1'b1);
                else if (s == 4'd1) m = uop(op_sqd, 4'd0, 4'd1, 4'd6, 1'b1);
            end
        endcase
        return m;
    endfunction

    function automatic step_t last_step(func_t p);
        case (p)
            2'd0:    return 4'd0;
            2'd1:    return 4'd9;
            2'd2:    return 4'd7;
            default: return 4'd1;
        endcase
    endfunction

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= st_idle;
            prog      <= '0;
            pc        <= '0;
            drain_cnt <= '0;
            endflag   <= 1'b0;
        end else begin
            endflag <= 1'b0;
            case (state)
                st_idle: begin
                    if (run) begin
                        state <= st_issue;
                        prog  <= n_func;
                        pc    <= '0;
                    end
                end
                st_issue: begin
                    if (pc == last_step(prog)) begin
                        state     <= st_drain;
                        drain_cnt <= '0;
                    end else begin
                        pc <= pc + 4'd1;
                    end
                end
                st_drain: begin
                    // Wait until the last write-back has landed
                    if (drain_cnt == drain_w'(`LAT_WB - 1)) begin
                        state   <= st_idle;
                        pc      <= '0;
                        endflag <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign busy = (state != st_idle);

    always_comb begin
        mop_o.mop = (state == st_issue) ? rom_word(prog, pc) : mop_nop;
    end

endmodule

`default_nettype wire

// ==== design/operand_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fp_consts.svh"

module operand_ram
    import fp_types_pkg::*;
(
    input  wire         clk,
    input  wire         we,
    input  wire raddr_t waddr,
    input  wire fe_t    wdata,
    input  wire raddr_t raddr,
    output fe_t         rdata
);

    fe_t mem [`RF_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== sim/fp_core_tests.svh ====
`ifndef FP_CORE_TESTS_SVH
`define FP_CORE_TESTS_SVH

////////////////////
// Field reference
////////////////////

function automatic fe_t mul_mod(fe_t a, fe_t b);
    return fe_t'((longint'(a) * longint'(b)) % prime);
endfunction

function automatic fe_t add_mod(fe_t a, fe_t b);
    return fe_t'((longint'(a) + longint'(b)) % prime);
endfunction

function automatic fe_t sub_mod(fe_t a, fe_t b);
    return fe_t'((longint'(a) - longint'(b) + prime) % prime);
endfunction

// Zero has no nonzero negative
function automatic fe_t negate_mod(fe_t v);
    return (v == 0) ? fe_t'(0) : fe_t'(prime - longint'(v));
endfunction

////////////////////
// Directed tests
////////////////////

task automatic load_and_readback();
    fe_t pattern [`RF_DEPTH];
    fe_t got;
    int  errs;
    errs = err_cnt;
    for (int i = 0; i < `RF_DEPTH; i++) begin
        pattern[i] = rand_fe();
        load_word(raddr_t'(i), pattern[i]);
    end
    for (int i = 0; i < `RF_DEPTH; i++) begin
        read_word(raddr_t'(i), got);
        compare_value($sformatf("ext_rd_data[%0d]", i), pattern[i], got);
    end
    report_test("load_and_readback", errs);
endtask

task automatic product_program();
    fe_t a [6];
    fe_t b [6];
    fe_t got;
    int  errs;
    errs = err_cnt;
    for (int i = 0; i < 4; i++) begin
        a[i] = rand_fe();
        b[i] = rand_fe();
    end
    // Largest operands, then a zero factor
    a[4] = 16'd65520;
    b[4] = 16'd65520;
    a[5] = 16'd0;
    b[5] = rand_fe();
    for (int i = 0; i < 6; i++) begin
        load_word(4'd0, a[i]);
        load_word(4'd1, b[i]);
        run_program(2'd0);
        read_word(4'd2, got);
        compare_value("m2", mul_mod(a[i], b[i]), got);
    end
    report_test("product_program", errs);
endtask

task automatic sum_diff_program();
    fe_t a;
    fe_t b;
    fe_t got;
    int  errs;
    errs = err_cnt;
    for (int i = 0; i < 4; i++) begin
        // m0 below m1 so the difference wraps
        a = fe_t'($urandom % 32760);
        b = fe_t'(32768 + $urandom % 32753);
        if (i == 3) begin
            a = 16'd1;
            b = 16'd65520;
        end
        load_word(4'd0, a);
        load_word(4'd1, b);
        run_program(2'd1);
        read_word(4'd2, got);
        compare_value("m2", add_mod(a, b), got);
        read_word(4'd3, got);
        compare_value("m3", sub_mod(a, b), got);
        read_word(4'd4, got);
        compare_value("m4", mul_mod(add_mod(a, b), sub_mod(a, b)), got);
        read_word(4'd0, got);
        compare_value("m0", a, got);
        read_word(4'd1, got);
        compare_value("m1", b, got);
    end
    report_test("sum_diff_program", errs);
endtask

task automatic fourth_power_program();
    fe_t a;
    fe_t sq;
    fe_t got;
    int  errs;
    errs = err_cnt;
    for (int i = 0; i < 4; i++) begin
        a = (i == 3) ? fe_t'(16'd65520) : rand_fe();
        sq = mul_mod(a, a);
        load_word(4'd0, a);
        run_program(2'd2);
        read_word(4'd1, got);
        compare_value("m1", mul_mod(sq, sq), got);
    end
    report_test("fourth_power_program", errs);
endtask

task automatic negated_program();
    fe_t a;
    fe_t b;
    fe_t got;
    int  errs;
    errs = err_cnt;
    for (int i = 0; i < 5; i++) begin
        a = rand_fe();
        b = rand_fe();
        // Zero product, then equal operands for a zero difference of squares
        if (i == 3) a = 16'd0;
        if (i == 4) b = a;
        load_word(4'd0, a);
        load_word(4'd1, b);
        run_program(2'd3);
        read_word(4'd5, got);
        compare_value("m5", negate_mod(mul_mod(a, b)), got);
        read_word(4'd6, got);
        compare_value("m6", negate_mod(sub_mod(mul_mod(a, a), mul_mod(b, b))), got);
    end
    report_test("negated_program", errs);
endtask

task automatic busy_isolation();
    fe_t a;
    fe_t b;
    fe_t got;
    int  pulses_before;
    int  errs;
    errs = err_cnt;
    a = rand_fe();
    b = rand_fe();
    load_word(4'd0, a);
    load_word(4'd1, b);
    pulses_before = end_pulses;
    start_program(2'd0);
    // Second start and a host write while busy
    @(posedge clk);
    run         <= 1'b1;
    n_func      <= 2'd2;
    ext_wr_en   <= 1'b1;
    ext_wr_addr <= 4'd0;
    ext_wr_data <= rand_fe();
    @(posedge clk);
    run       <= 1'b0;
    ext_wr_en <= 1'b0;
    @(negedge clk);
    wait_for_end();
    // A remembered second start would raise busy right after endflag
    @(negedge clk);
    compare_value("busy", 0, busy);
    // Long enough for a restarted program to show up
    repeat (20) @(negedge clk);
    compare_value("endflag pulses", 1, end_pulses - pulses_before);
    read_word(4'd2, got);
    compare_value("m2", mul_mod(a, b), got);
    read_word(4'd0, got);
    compare_value("m0", a, got);
    report_test("busy_isolation", errs);
endtask

`endif

// ==== sim/fp_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fp_consts.svh"

module fp_core_tb
    import fp_types_pkg::*;
();

    // Six tests of at most about 300 cycles each, plus reset
    localparam int     max_cycles = 2000;
    localparam longint prime      = `FP_P;
    localparam int     end_wait   = 64;

    logic   clk;
    logic   rstn;
    logic   run;
    func_t  n_func;
    logic   ext_wr_en;
    raddr_t ext_wr_addr;
    fe_t    ext_wr_data;
    raddr_t ext_rd_addr;
    logic   busy;
    logic   endflag;
    fe_t    ext_rd_data;

    int cycle_cnt;
    int err_cnt;
    int check_cnt;
    int test_cnt;
    int end_pulses;

    fp_core i_dut (
        .clk, .rstn, .run, .n_func,
        .ext_wr_en, .ext_wr_addr, .ext_wr_data, .ext_rd_addr,
        .busy, .endflag, .ext_rd_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Counts every endflag pulse after reset
    always @(negedge clk) begin
        if (rstn && endflag) begin
            end_pulses++;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic compare_value(string name, int unsigned expected, int unsigned actual);
        check_cnt++;
        assert (expected == actual) else begin
            $display("error at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic fe_t rand_fe();
        return fe_t'($urandom % `FP_P);
    endfunction

    task automatic load_word(raddr_t addr, fe_t data);
        @(posedge clk);
        ext_wr_en   <= 1'b1;
        ext_wr_addr <= addr;
        ext_wr_data <= data;
        @(posedge clk);
        ext_wr_en   <= 1'b0;
    endtask

    // Data is registered, so it shows one cycle after the address
    task automatic read_word(raddr_t addr, output fe_t data);
        @(posedge clk);
        ext_rd_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = ext_rd_data;
    endtask

    task automatic start_program(func_t prog);
        @(posedge clk);
        run    <= 1'b1;
        n_func <= prog;
        @(posedge clk);
        run    <= 1'b0;
        @(negedge clk);
        compare_value("busy", 1, busy);
    endtask

    task automatic wait_for_end();
        int   waited;
        logic busy_before;
        waited      = 0;
        busy_before = busy;
        while (!endflag && waited < end_wait) begin
            busy_before = busy;
            @(negedge clk);
            waited++;
        end
        if (!endflag) begin
            $display("Program did not raise endflag within %0d cycles", end_wait);
            err_cnt++;
        end else begin
            // busy drops together with the endflag pulse
            compare_value("busy", 0, busy);
            compare_value("busy before endflag", 1, busy_before);
        end
    endtask

    task automatic run_program(func_t prog);
        start_program(prog);
        wait_for_end();
    endtask

    task automatic report_test(string name, int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    `include "fp_core_tests.svh"

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(97744));
        rstn        = 1'b0;
        run         = 1'b0;
        n_func      = '0;
        ext_wr_en   = 1'b0;
        ext_wr_addr = '0;
        ext_wr_data = '0;
        ext_rd_addr = '0;
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        end_pulses  = 0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        load_and_readback();
        product_program();
        sum_diff_program();
        fourth_power_program();
        negated_program();
        busy_isolation();

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", max_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
+incdir+sim
design/fp_types_pkg.sv
design/mop_pkg.sv
design/mop_if.sv
design/mop_sequencer.sv
design/operand_ram.sv
design/fp_preadder.sv
design/fp_mod_mul.sv
design/fp_core.sv
sim/fp_core_tb.sv
